//--- bexkat_exec.f
hw/isa_pkg.sv
hw/exc_pkg.sv
hw/exec_unit_if.sv
hw/alu_comb.sv
hw/int_calc.sv
hw/execute.sv
hw/exec_core.sv
testbench/exec_assert.sv
testbench/exec_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the execute stage testbench with Verilator

verilator --binary --timing --assert -Wno-fatal --top-module exec_tb \
  -f bexkat_exec.f -o exec_sim > build.log 2>&1 \
  || { echo "build failed, see build.log"; exit 1; }

./obj_dir/exec_sim > sim.log 2>&1 \
  || { echo "simulation aborted, see sim.log"; exit 1; }

grep -q "Test FAILED" sim.log \
  && { echo "simulation failed, see sim.log"; exit 1; } \
  || { echo "simulation passed"; exit 0; }

//--- testbench/exec_tb.sv
`timescale 1ns/10ps

module exec_tb;
  import isa_pkg::*;
  import exc_pkg::*;

  localparam int STALL_TIMEOUT = 20;

  logic          clk_i;
  logic          rst_i;
  logic [63:0]   ir_i;
  logic [31:0]   pc_i;
  logic [31:0]   reg_data1_i;
  logic [31:0]   reg_data2_i;
  logic [1:0]    reg_write_i;
  logic [3:0]    bank_i;
  logic          stall_i;
  logic [2:0]    interrupts_i;
  logic [31:0]   result_o;
  logic [31:0]   reg_data1_o;
  logic [1:0]    reg_write_o;
  ccr_t          ccr_o;
  logic          halt_o;
  logic [3:0]    bank_o;
  logic          stall_o;
  logic [63:0]   ir_o;
  logic          supervisor_o;
  logic          interrupts_enabled_o;
  logic          exc_o;
  logic [31:0]   pc_o;
  logic          pc_set_o;

  integer        seed = 32'h8aba3f61;
  int            errors = 0;
  int            checks = 0;
  ccr_t          m_ccr;
  logic [31:0]   m_vbase;
  logic [31:0]   cmp_a;
  logic [31:0]   cmp_b;
  logic [31:0]   a;
  logic [31:0]   b;
  logic [31:0]   imm_s;
  logic [14:0]   imm;
  logic [3:0]    op;
  logic [31:0]   base;
  logic [2:0]    irq;
  logic          taken;
  int            cnt;
  int            span;
  logic [31:0]   snap_result;
  logic [31:0]   snap_pc;
  logic [63:0]   snap_ir;
  ccr_t          snap_ccr;
  logic          snap_pc_set;
  logic [1:0]    snap_rw;

  exec_core exec_core_i (.*);

  always #50 clk_i = ~clk_i;

  function automatic logic [63:0] make_ir(insn_type_t t, logic [3:0] o, logic [14:0] i,
                                          logic sz, logic [31:0] ext);
    return {ext, t, o, 8'h00, i, sz};
  endfunction

  function automatic logic [31:0] sext(logic [14:0] i);
    return {{17{i[14]}}, i};
  endfunction

  function automatic logic [31:0] alu_ref(logic [2:0] f, logic [31:0] x, logic [31:0] y);
    case (f)
      3'd0: return x + y;
      3'd1: return x - y;
      3'd2: return x & y;
      3'd3: return x | y;
      3'd4: return x ^ y;
      3'd5: return x << y[4:0];
      3'd6: return x >> y[4:0];
      default: return $unsigned($signed(x) >>> y[4:0]);
    endcase
  endfunction

  function automatic logic [31:0] int_ref(logic uns, logic [1:0] f, logic [31:0] x,
                                          logic [31:0] y);
    longint sx;
    longint sy;
    sx = longint'($signed(x));
    sy = longint'($signed(y));
    if (f != 2'd0 && y == 0)
      return (f == 2'd1) ? 32'hffffffff : x;  // divide by zero
    if (uns)
      return (f == 2'd0) ? x * y : (f == 2'd1) ? x / y : x % y;
    return (f == 2'd0) ? 32'(sx * sy) : (f == 2'd1) ? 32'(sx / sy) : 32'(sx % sy);
  endfunction

  function automatic logic branch_ref(logic [3:0] c, logic [31:0] x, logic [31:0] y);
    case (c)
      4'd0: return 1'b1;
      4'd1: return x == y;
      4'd2: return x != y;
      4'd3: return x > y;
      4'd4: return $signed(x) > $signed(y);
      4'd5: return $signed(x) >= $signed(y);
      4'd6: return $signed(x) <= $signed(y);
      4'd7: return $signed(x) < $signed(y);
      4'd8: return x >= y;
      4'd9: return x < y;
      4'd10: return x <= y;
      default: return 1'b0;
    endcase
  endfunction

  task automatic check(input string name, input logic [63:0] exp, input logic [63:0] act);
    checks++;
    assert (exp === act)
    else
    begin
      errors++;
      $display("ERROR %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic end_run();
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("Test OK");
    else
      $display("Test FAILED");
    $finish;
  endtask

  task automatic next_cycle();
    @(posedge clk_i);
    #1;
  endtask

  task automatic issue(input logic [63:0] ir, input logic [31:0] r1, input logic [31:0] r2);
    ir_i = ir;
    reg_data1_i = r1;
    reg_data2_i = r2;
    pc_i = $random(seed);
    reg_write_i = $random(seed);
    bank_i = $random(seed);
  endtask

  task automatic nop();
    issue(make_ir(T_INH, 4'h0, 15'h0, 1'b0, 32'h0), 32'h0, 32'h0);
    next_cycle();
    check("exc pulse end", 0, exc_o);
  endtask

  task automatic do_reset();
    rst_i = 1'b1;
    repeat (5) next_cycle();
    rst_i = 1'b0;
    m_ccr = '0;
    m_vbase = VECT_RESET;
    check("reset halt", 0, halt_o);
    check("reset supervisor", 1, supervisor_o);
    check("reset ie", 0, interrupts_enabled_o);
    check("reset exc", 0, exc_o);
    check("reset pc_set", 0, pc_set_o);
    check("reset reg_write", 0, reg_write_o);
  endtask

  task automatic trap_and_check(input string name);
    imm = $random(seed);
    issue(make_ir(T_INH, OP_TRAP, imm, 1'b0, 32'h0), 32'h0, 32'h0);
    next_cycle();
    check(name, 32'(m_vbase + (TRAP_SLOT_BASE * 4 + imm[1:0]) * VECT_STRIDE), result_o);
    check("trap exc", 1, exc_o);
    check("trap ie", 0, interrupts_enabled_o);
    nop();
  endtask

  initial
  begin
    clk_i = 1'b0;
    stall_i = 1'b0;
    interrupts_i = '0;
    issue(64'h0, 32'h0, 32'h0);
    do_reset();

    repeat (40)
    begin
      op = $random(seed);
      imm = $random(seed);
      a = $random(seed);
      b = $random(seed);
      base = $random(seed);
      if ($random(seed) & 1)
      begin
        issue(make_ir(T_ALU, op, imm, 1'b0, 32'h0), a, b);
        next_cycle();
        check("alu result", alu_ref(op[2:0], a, op[3] ? sext(imm) : b), result_o);
      end
      else
      begin
        issue(make_ir(T_LDI, op, imm, op[0], base), a, b);
        next_cycle();
        check("ldi result", op[0] ? base : {17'h0, imm}, result_o);
      end
      check("pass reg_data1", reg_data1_i, reg_data1_o);
      check("pass reg_write", reg_write_i, reg_write_o);
      check("pass bank", bank_i, bank_o);
      check("pass ir", ir_i, ir_o);
      check("pass pc", pc_i, pc_o);
      check("ccr kept", m_ccr, ccr_o);
    end

    repeat (30)
    begin
      cmp_a = $random(seed);
      cmp_b = (($random(seed) & 3) == 0) ? cmp_a : $random(seed);
      issue(make_ir(T_CMP, 4'h0, 15'h0, 1'b0, 32'h0), cmp_a, cmp_b);
      next_cycle();
      m_ccr = '{ltu: cmp_a < cmp_b, lt: $signed(cmp_a) < $signed(cmp_b), eq: cmp_a == cmp_b};
      check("cmp ccr", m_ccr, ccr_o);
      op = $unsigned($random(seed)) % 12;
      imm = $random(seed);
      issue(make_ir(T_BRANCH, op, imm, 1'b0, 32'h0), 32'h0, 32'h0);
      next_cycle();
      taken = branch_ref(op, cmp_a, cmp_b);
      check("branch pc_set", taken, pc_set_o);
      check("branch pc", taken ? 32'(pc_i + (sext(imm) << 2)) : pc_i, pc_o);
    end

    repeat (12)
    begin
      op = {1'($random(seed)), 1'b0, 2'($unsigned($random(seed)) % 3)};
      imm = $random(seed);
      a = $random(seed);
      b = (($random(seed) & 7) == 0) ? 32'h0 : $random(seed);
      taken = $random(seed) & 1;  // unsigned form
      issue(make_ir(taken ? T_INTU : T_INT, op, imm, 1'b0, 32'h0), a, b);
      cnt = 1;
      next_cycle();
      while (stall_o)
      begin
        cnt++;
        if (cnt > STALL_TIMEOUT)
        begin
          errors++;
          $display("stall_o did not fall within %0d cycles", STALL_TIMEOUT);
          end_run();
        end
        next_cycle();
      end
      check("int stall length", INT_LATENCY, cnt);
      next_cycle();
      check("int result", int_ref(taken, op[1:0], a, op[3] ? sext(imm) : b), result_o);
    end

    repeat (4)
    begin
      issue(make_ir(T_INH, OP_STI, 15'h0, 1'b0, 32'h0), 32'h0, 32'h0);
      next_cycle();
      check("sti ie", 1, interrupts_enabled_o);
      irq = ($unsigned($random(seed)) % 7) + 1;
      issue(make_ir(T_INH, 4'h0, 15'h0, 1'b0, 32'h0), 32'h0, 32'h0);
      interrupts_i = irq;
      next_cycle();
      interrupts_i = '0;
      check("irq vector", m_vbase + irq * VECT_STRIDE, result_o);
      check("irq exc", 1, exc_o);
      check("irq ie", 0, interrupts_enabled_o);
      nop();
      issue(make_ir(T_INH, OP_STI, 15'h0, 1'b0, 32'h0), 32'h0, 32'h0);
      next_cycle();
      trap_and_check("trap vector");
    end

    base = $random(seed) & 32'hffffff00;
    issue(make_ir(T_INH, OP_TRAP, 15'h0, 1'b1, base), 32'h0, 32'h0);
    next_cycle();
    m_vbase = base;
    check("setint halt", 0, halt_o);
    trap_and_check("trap after setint");
    issue(make_ir(T_MOV, OP_MOV_TO_SR, 15'h0, 1'b0, 32'h0), 32'h5, 32'h0);
    next_cycle();
    m_ccr = 3'b101;
    check("user supervisor", 0, supervisor_o);
    check("mov ccr", m_ccr, ccr_o);
    issue(make_ir(T_MOV, OP_MOV_FROM_SR, 15'h0, 1'b0, 32'h0), 32'h0, 32'h0);
    next_cycle();
    check("status word", 32'h5, result_o);
    issue(make_ir(T_INH, OP_TRAP, 15'h0, 1'b1, 32'h1000), 32'h0, 32'h0);
    next_cycle();
    check("user setint halt", 1, halt_o);
    do_reset();
    issue(make_ir(T_MOV, OP_MOV_TO_SR, 15'h0, 1'b0, 32'h0), 32'h0, 32'h0);
    next_cycle();
    issue(make_ir(T_INH, OP_RESET, 15'h0, 1'b0, 32'h0), 32'h0, 32'h0);
    next_cycle();
    check("user reset halt", 1, halt_o);
    do_reset();
    issue(make_ir(T_INH, OP_RESET, 15'h0, 1'b0, 32'h0), 32'h0, 32'h0);
    next_cycle();
    check("reset vector", VECT_RESET, result_o);
    check("reset exc", 1, exc_o);
    nop();

    repeat (6)
    begin
      imm = $random(seed);
      issue(make_ir(T_BRANCH, 4'h0, imm, 1'b0, 32'h0), 32'h0, 32'h0);  // bra
      next_cycle();
      check("bra pc_set", 1, pc_set_o);
      snap_result = result_o;
      snap_pc = pc_o;
      snap_ir = ir_o;
      snap_ccr = ccr_o;
      snap_pc_set = pc_set_o;
      snap_rw = reg_write_o;
      a = $random(seed);
      b = $random(seed);
      issue(make_ir(T_CMP, 4'h0, 15'h0, 1'b0, 32'h0), a, b);
      stall_i = 1'b1;
      span = ($unsigned($random(seed)) % 5) + 1;
      repeat (span)
      begin
        next_cycle();
        check("hold result", snap_result, result_o);
        check("hold pc", snap_pc, pc_o);
        check("hold ir", snap_ir, ir_o);
        check("hold ccr", snap_ccr, ccr_o);
        check("hold pc_set", snap_pc_set, pc_set_o);
        check("hold reg_write", snap_rw, reg_write_o);
      end
      stall_i = 1'b0;
      next_cycle();
      m_ccr = '{ltu: a < b, lt: $signed(a) < $signed(b), eq: a == b};
      check("ccr after hold", m_ccr, ccr_o);
      check("pc after hold", pc_i, pc_o);
      check("pc_set after hold", 0, pc_set_o);
    end

    end_run();
  end

endmodule

//--- testbench/exec_assert.sv
`timescale 1ns/10ps

module exec_assert (
  input logic          clk_i,
  input logic          rst_i,
  input logic          stall_i,
  input logic          stall_o,
  input logic          exc_o,
  input logic          pc_set_o,
  input logic [31:0]   result_o,
  input logic [31:0]   pc_o,
  input logic [63:0]   ir_o,
  input logic [1:0]    reg_write_o,
  input exc_pkg::ccr_t ccr_o
);
  import isa_pkg::*;

  logic [3:0] stall_run;  // consecutive stall cycles

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
      stall_run <= '0;
    else if (stall_o)
      stall_run <= stall_run + 1'b1;
    else
      stall_run <= '0;
  end

  stall_len: assert property (@(posedge clk_i) disable iff (rst_i)
    stall_o |-> stall_run < INT_LATENCY)
    else $error("stall_o high longer than the integer latency");

  exc_pulse: assert property (@(posedge clk_i) disable iff (rst_i)
    exc_o |=> !exc_o)
    else $error("exc_o longer than one cycle");

  hold_outputs: assert property (@(posedge clk_i) disable iff (rst_i)
    stall_i |=> $stable(result_o) && $stable(pc_o) && $stable(ir_o) && $stable(ccr_o)
      && $stable(pc_set_o) && $stable(reg_write_o))
    else $error("outputs changed while stall_i was high");

endmodule

bind execute exec_assert chk_i (.*);

//--- hw/exec_core.sv
`timescale 1ns/10ps

module exec_core (
  input  logic          clk_i,
  input  logic          rst_i,
  input  logic [63:0]   ir_i,
  input  logic [31:0]   pc_i,
  input  logic [31:0]   reg_data1_i,
  input  logic [31:0]   reg_data2_i,
  input  logic [1:0]    reg_write_i,
  input  logic [3:0]    bank_i,
  input  logic          stall_i,
  input  logic [2:0]    interrupts_i,
  output logic [31:0]   result_o,
  output logic [31:0]   reg_data1_o,
  output logic [1:0]    reg_write_o,
  output exc_pkg::ccr_t ccr_o,
  output logic          halt_o,
  output logic [3:0]    bank_o,
  output logic          stall_o,
  output logic [63:0]   ir_o,
  output logic          supervisor_o,
  output logic          interrupts_enabled_o,
  output logic          exc_o,
  output logic [31:0]   pc_o,
  output logic          pc_set_o
);

  exec_unit_if eu ();

  execute exe_i (
    .clk_i                (clk_i),
    .rst_i                (rst_i),
    .ir_i                 (ir_i),
    .pc_i                 (pc_i),
    .reg_data1_i          (reg_data1_i),
    .reg_data2_i          (reg_data2_i),
    .reg_write_i          (reg_write_i),
    .bank_i               (bank_i),
    .stall_i              (stall_i),
    .interrupts_i         (interrupts_i),
    .result_o             (result_o),
    .reg_data1_o          (reg_data1_o),
    .reg_write_o          (reg_write_o),
    .ccr_o                (ccr_o),
    .halt_o               (halt_o),
    .bank_o               (bank_o),
    .stall_o              (stall_o),
    .ir_o                 (ir_o),
    .supervisor_o         (supervisor_o),
    .interrupts_enabled_o (interrupts_enabled_o),
    .exc_o                (exc_o),
    .pc_o                 (pc_o),
    .pc_set_o             (pc_set_o),
    .eu                   (eu.stage)
  );

  alu_comb alu_i (
    .eu (eu.alu)
  );

  int_calc int_i (
    .eu (eu.intu)
  );

endmodule

//--- hw/execute.sv
`timescale 1ns/10ps

module execute (
  input  logic          clk_i,
  input  logic          rst_i,
  input  logic [63:0]   ir_i,
  input  logic [31:0]   pc_i,
  input  logic [31:0]   reg_data1_i,
  input  logic [31:0]   reg_data2_i,
  input  logic [1:0]    reg_write_i,
  input  logic [3:0]    bank_i,
  input  logic          stall_i,
  input  logic [2:0]    interrupts_i,
  output logic [31:0]   result_o,
  output logic [31:0]   reg_data1_o,
  output logic [1:0]    reg_write_o,
  output exc_pkg::ccr_t ccr_o,
  output logic          halt_o,
  output logic [3:0]    bank_o,
  output logic          stall_o,
  output logic [63:0]   ir_o,
  output logic          supervisor_o,
  output logic          interrupts_enabled_o,
  output logic          exc_o,
  output logic [31:0]   pc_o,
  output logic          pc_set_o,
  exec_unit_if.stage    eu
);
  import isa_pkg::*;
  import exc_pkg::*;

  insn_type_t           ir_type;
  logic [3:0]           ir_op;
  logic [31:0]          ir_ext;
  logic [31:0]          ir_sval;
  logic [31:0]          ir_uval;
  logic [31:0]          ir_scaled;
  logic                 ir_size;
  logic                 hold;
  logic                 int_irq;
  logic                 stall_start;
  logic [INT_CNT_W-1:0] delay;
  logic [INT_CNT_W-1:0] delay_next;
  logic [31:0]          vect_base;
  logic [31:0]          vect_base_next;
  logic [31:0]          irq_vect;
  logic [31:0]          trap_vect;
  logic [31:0]          result_next;
  logic [31:0]          pc_next;
  logic                 pc_set_next;
  logic                 br_take;
  ccr_t                 ccr_next;
  logic                 halt_next;
  logic                 ie_next;
  logic                 exc_next;
  logic                 sup_next;

  assign ir_type   = insn_type_t'(ir_i[TYPE_HI:TYPE_LO]);
  assign ir_op     = ir_i[OP_HI:OP_LO];
  assign ir_ext    = ir_i[EXT_HI:EXT_LO];
  assign ir_sval   = {{(32 - IMM_W){ir_i[IMM_HI]}}, ir_i[IMM_HI:IMM_LO]};
  assign ir_uval   = {{(32 - IMM_W){1'b0}}, ir_i[IMM_HI:IMM_LO]};
  assign ir_scaled = {ir_sval[29:0], 2'b00};  // word offset
  assign ir_size   = ir_i[SIZE_BIT];

  assign stall_start = (ir_type == T_INT || ir_type == T_INTU) && (delay == '0);
  assign stall_o     = stall_start || (delay > 1);
  assign hold        = stall_i || stall_o;
  assign int_irq     = (|interrupts_i) && interrupts_enabled_o;

  assign irq_vect  = vect_base + 32'(interrupts_i * VECT_STRIDE);
  assign trap_vect = vect_base + 32'((TRAP_SLOT_BASE * 4 + ir_uval[1:0]) * VECT_STRIDE);

  always_comb
  begin
    delay_next = delay;
    if (stall_start)
      delay_next = INT_CNT_W'(INT_LATENCY);
    else if (delay != '0 && !(delay == 1 && stall_i))  // last step waits for the result latch
      delay_next = delay - 1'b1;
  end

  always_comb
  begin
    eu.in1 = reg_data1_i;
    eu.in2 = reg_data2_i;
    eu.alu_func = alu_func_t'(ir_op[2:0]);
    eu.int_func = int_func_t'({ir_type == T_INTU, ir_op[2:0]});
    case (ir_type)
      T_ALU, T_INT, T_INTU:
        if (ir_op[3])
          eu.in2 = ir_sval;  // immediate form
      T_CMP:
        eu.alu_func = ALU_SUB;
      T_LOAD, T_STORE:
      begin
        eu.alu_func = ALU_ADD;
        if (!ir_size)
          eu.in1 = ir_scaled;
      end
      T_PUSH:
      begin
        eu.alu_func = ALU_ADD;
        if (!ir_size)
        begin
          eu.in1 = pc_i;
          eu.in2 = ir_scaled;
        end
      end
      T_BRANCH:
      begin
        eu.alu_func = ALU_ADD;
        eu.in1 = pc_i;
        eu.in2 = ir_scaled;
      end
      T_JUMP:
      begin
        eu.alu_func = ALU_ADD;
        if (!ir_size)
          eu.in2 = ir_scaled;
      end
      default: ;
    endcase
  end

  always_comb
  begin
    if (int_irq)
      result_next = irq_vect;
    else
      case (ir_type)
        T_INH:
          if (ir_op == OP_RESET)
            result_next = vect_base;
          else if (ir_op == OP_TRAP && !ir_size)
            result_next = trap_vect;
          else
            result_next = eu.alu_out;
        T_INT, T_INTU:
          result_next = eu.int_out;
        T_LOAD, T_STORE:
          result_next = ir_size ? ir_ext : eu.alu_out;
        T_LDI:
          result_next = ir_size ? ir_ext : ir_uval;
        T_MOV:
          if (ir_op == OP_MOV_FROM_SR)
            result_next = {28'h0, supervisor_o, ccr_o};  // status word
          else
            result_next = reg_data1_i;
        default:
          result_next = eu.alu_out;
      endcase
  end

  always_comb
  begin
    case (ir_op)
      4'h0: br_take = 1'b1;                      // bra
      4'h1: br_take = ccr_o.eq;                  // beq
      4'h2: br_take = !ccr_o.eq;                 // bne
      4'h3: br_take = !(ccr_o.ltu || ccr_o.eq);  // bgtu
      4'h4: br_take = !(ccr_o.lt || ccr_o.eq);   // bgt
      4'h5: br_take = !ccr_o.lt;                 // bge
      4'h6: br_take = ccr_o.lt || ccr_o.eq;      // ble
      4'h7: br_take = ccr_o.lt;                  // blt
      4'h8: br_take = !ccr_o.ltu;                // bgeu
      4'h9: br_take = ccr_o.ltu;                 // bltu
      4'ha: br_take = ccr_o.ltu || ccr_o.eq;     // bleu
      default: br_take = 1'b0;
    endcase
  end

  always_comb
  begin
    pc_next = pc_i;
    pc_set_next = 1'b0;
    case (ir_type)
      T_BRANCH:
        if (br_take)
        begin
          pc_next = eu.alu_out;
          pc_set_next = 1'b1;
        end
      T_PUSH, T_JUMP:
      begin
        pc_next = ir_size ? ir_ext : eu.alu_out;
        pc_set_next = 1'b1;
      end
      default: ;
    endcase
  end

  always_comb
  begin
    halt_next = halt_o;
    ie_next = interrupts_enabled_o;
    vect_base_next = vect_base;
    sup_next = supervisor_o;
    exc_next = 1'b0;
    ccr_next = ccr_o;
    if (!hold)
    begin
      if (int_irq)
      begin
        ie_next = 1'b0;
        exc_next = 1'b1;
      end
      else
        case (ir_type)
          T_MOV:
            if (ir_op == OP_MOV_TO_SR)
            begin
              ccr_next = ccr_t'(reg_data1_i[2:0]);
              sup_next = reg_data1_i[3];
            end
          T_CMP:
            ccr_next = '{ltu: eu.alu_c, lt: eu.alu_n ^ eu.alu_v, eq: eu.alu_z};
          T_INH:
            case (ir_op)
              OP_TRAP:
                if (!ir_size)
                begin
                  exc_next = 1'b1;
                  ie_next = 1'b0;
                end
                else if (supervisor_o)
                  vect_base_next = ir_ext;  // setint
                else
                  halt_next = 1'b1;
              OP_CLI:
                ie_next = 1'b0;
              OP_STI:
                ie_next = 1'b1;
              OP_HALT:
                halt_next = 1'b1;
              OP_RESET:
                if (supervisor_o)
                begin
                  exc_next = 1'b1;
                  ie_next = 1'b0;
                end
                else
                  halt_next = 1'b1;
              default: ;
            endcase
          default: ;
        endcase
    end
  end

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      delay <= '0;
      halt_o <= 1'b0;
      exc_o <= 1'b0;
      interrupts_enabled_o <= 1'b0;
      supervisor_o <= 1'b1;
      vect_base <= VECT_RESET;
      ir_o <= '0;
      reg_write_o <= '0;
      ccr_o <= '0;
      pc_set_o <= 1'b0;
    end
    else
    begin
      delay <= delay_next;
      halt_o <= halt_next;
      exc_o <= exc_next;
      interrupts_enabled_o <= ie_next;
      supervisor_o <= sup_next;
      vect_base <= vect_base_next;
      if (!hold)
      begin
        ir_o <= ir_i;
        reg_write_o <= reg_write_i;
        ccr_o <= ccr_next;
        pc_set_o <= pc_set_next;
      end
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (!hold)
    begin
      result_o <= result_next;
      pc_o <= pc_next;
      reg_data1_o <= reg_data1_i;
      bank_o <= bank_i;  // passes through
    end
  end

endmodule

//--- hw/int_calc.sv
`timescale 1ns/10ps

module int_calc (
  exec_unit_if.intu eu
);
  import isa_pkg::*;

  logic signed [31:0] s1;
  logic signed [31:0] s2;
  logic               div_zero;
  logic               div_ovf;

  assign s1       = eu.in1;
  assign s2       = eu.in2;
  assign div_zero = (eu.in2 == 32'h0);
  assign div_ovf  = (eu.in1 == 32'h80000000) && (eu.in2 == 32'hffffffff);  // min / -1

  always_comb
  begin
    case (eu.int_func)
      INT_MUL:
        eu.int_out = 32'(s1 * s2);
      INT_DIV:
        if (div_zero)
          eu.int_out = '1;
        else if (div_ovf)
          eu.int_out = eu.in1;
        else
          eu.int_out = 32'(s1 / s2);
      INT_MOD:
        if (div_zero)
          eu.int_out = eu.in1;
        else if (div_ovf)
          eu.int_out = '0;
        else
          eu.int_out = 32'(s1 % s2);
      INT_MULU:
        eu.int_out = eu.in1 * eu.in2;
      INT_DIVU:
        eu.int_out = div_zero ? '1 : eu.in1 / eu.in2;
      INT_MODU:
        eu.int_out = div_zero ? eu.in1 : eu.in1 % eu.in2;
      default:
        eu.int_out = '0;
    endcase
  end

endmodule

//--- hw/alu_comb.sv
`timescale 1ns/10ps

module alu_comb (
  exec_unit_if.alu eu
);
  import isa_pkg::*;

  logic [32:0] sum;
  logic [32:0] diff;
  logic [31:0] res;

  assign sum  = {1'b0, eu.in1} + {1'b0, eu.in2};
  assign diff = {1'b0, eu.in1} - {1'b0, eu.in2};  // bit 32 is the borrow

  always_comb
  begin
    eu.alu_c = 1'b0;
    eu.alu_v = 1'b0;
    case (eu.alu_func)
      ALU_ADD:
      begin
        res = sum[31:0];
        eu.alu_c = sum[32];
        eu.alu_v = (eu.in1[31] == eu.in2[31]) && (res[31] != eu.in1[31]);
      end
      ALU_SUB:
      begin
        res = diff[31:0];
        eu.alu_c = diff[32];
        eu.alu_v = (eu.in1[31] != eu.in2[31]) && (res[31] != eu.in1[31]);
      end
      ALU_AND:
        res = eu.in1 & eu.in2;
      ALU_OR:
        res = eu.in1 | eu.in2;
      ALU_XOR:
        res = eu.in1 ^ eu.in2;
      ALU_SHL:
        res = eu.in1 << eu.in2[4:0];
      ALU_SHR:
        res = eu.in1 >> eu.in2[4:0];
      ALU_ASR:
        res = 32'($signed(eu.in1) >>> eu.in2[4:0]);
      default:
        res = '0;
    endcase
  end

  assign eu.alu_out = res;
  assign eu.alu_n   = res[31];
  assign eu.alu_z   = (res == 32'h0);

endmodule

//--- hw/exec_unit_if.sv
`timescale 1ns/10ps

interface exec_unit_if;
  import isa_pkg::*;

  logic [31:0] in1;
  logic [31:0] in2;
  alu_func_t   alu_func;
  int_func_t   int_func;
  logic [31:0] alu_out;
  logic [31:0] int_out;
  logic        alu_c;
  logic        alu_n;
  logic        alu_v;
  logic        alu_z;

  modport stage (
    output in1, in2, alu_func, int_func,
    input  alu_out, int_out, alu_c, alu_n, alu_v, alu_z
  );

  modport alu (
    input  in1, in2, alu_func,
    output alu_out, alu_c, alu_n, alu_v, alu_z
  );

  modport intu (
    input  in1, in2, int_func,
    output int_out
  );

endinterface

//--- hw/exc_pkg.sv
package exc_pkg;

  typedef struct packed {
    logic ltu;
    logic lt;
    logic eq;
  } ccr_t;

  localparam logic [31:0] VECT_RESET = 32'hffffffc0;

  // trap n lands in slot TRAP_SLOT_BASE*4 + n, past the interrupt slots
  localparam int unsigned TRAP_SLOT_BASE = 3;
  localparam int unsigned VECT_STRIDE    = 8;

endpackage

//--- hw/isa_pkg.sv
package isa_pkg;

  typedef enum logic [3:0] {
    T_INH    = 4'h0,
    T_MOV    = 4'h1,
    T_CMP    = 4'h2,
    T_ALU    = 4'h3,
    T_INT    = 4'h4,
    T_INTU   = 4'h5,
    T_LOAD   = 4'h6,
    T_STORE  = 4'h7,
    T_LDI    = 4'h8,
    T_BRANCH = 4'h9,
    T_PUSH   = 4'ha,
    T_JUMP   = 4'hb
  } insn_type_t;

  typedef enum logic [2:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SHL, ALU_SHR, ALU_ASR
  } alu_func_t;

  // bit 3 selects the unsigned form
  typedef enum logic [3:0] {
    INT_MUL  = 4'h0,
    INT_DIV  = 4'h1,
    INT_MOD  = 4'h2,
    INT_MULU = 4'h8,
    INT_DIVU = 4'h9,
    INT_MODU = 4'ha
  } int_func_t;

  localparam int unsigned INT_LATENCY = 4;
  localparam int unsigned INT_CNT_W   = $clog2(INT_LATENCY + 1);

  localparam int unsigned TYPE_HI  = 31;
  localparam int unsigned TYPE_LO  = 28;
  localparam int unsigned OP_HI    = 27;
  localparam int unsigned OP_LO    = 24;
  localparam int unsigned IMM_HI   = 15;
  localparam int unsigned IMM_LO   = 1;
  localparam int unsigned IMM_W    = IMM_HI - IMM_LO + 1;
  localparam int unsigned SIZE_BIT = 0;
  localparam int unsigned EXT_HI   = 63;
  localparam int unsigned EXT_LO   = 32;

  localparam logic [3:0] OP_MOV_FROM_SR = 4'h0;
  localparam logic [3:0] OP_MOV_TO_SR   = 4'h4;
  localparam logic [3:0] OP_TRAP        = 4'h1;  // size bit set means setint
  localparam logic [3:0] OP_CLI         = 4'h2;
  localparam logic [3:0] OP_STI         = 4'h3;
  localparam logic [3:0] OP_HALT        = 4'h4;
  localparam logic [3:0] OP_RESET       = 4'h5;

endpackage
